// ==== sim/acc_vectors.txt ====
# columns (hex): address, write value, expected bresp, then AC, MQ, link after busy falls
# address 00 is the operand, 04 an instruction, anything else must give SLVERR (2)
04 EC0 0 000 000 0   CLA CLL
00 5A3 0 000 000 0
04 200 0 5A3 000 0   TAD
04 E31 0 A5D 000 1   CMA CML IAC
04 E04 0 4BB 000 1   RAL
04 E0A 0 D2E 000 1   RTR
04 E02 0 BB4 000 1   BSW
00 0F0 0 BB4 000 1
04 000 0 0B0 000 1   AND
00 F80 0 0B0 000 1
04 200 0 030 000 0   TAD, carry flips link
04 F11 0 000 030 0   MQL
00 123 0 000 030 0
04 200 0 123 030 0   TAD
04 F41 0 133 030 0   MQA
04 F51 0 030 133 0   SWP
04 F91 0 000 000 0   CAM
00 0C8 0 000 000 0
04 200 0 0C8 000 0   TAD
04 F11 0 000 0C8 0   MQL
00 017 0 000 0C8 0
04 200 0 017 0C8 0   TAD
00 03D 0 017 0C8 0
04 F05 0 002 FBF 0   MUL, 200 * 61 + 23
04 F07 0 017 0C8 0   DIV, 12223 / 61
00 010 0 017 0C8 0
04 F07 0 017 191 1   DIV overflow
08 555 2 017 191 1   write to AC register
10 001 2 017 191 1   write to status register

// ==== sim.f ====
hdl/pdp8_acc_pkg.sv
hdl/acc_cmd_if.sv
hdl/eae_if.sv
hdl/acc_axil_regs.sv
hdl/acc_datapath.sv
hdl/eae_muldiv.sv
hdl/acc_unit.sv
sim/acc_unit_properties.sv
sim/tb_acc_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the accumulator unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_acc_unit -f sim.f -o Vtb_acc_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_acc_unit +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== sim/tb_acc_unit.sv ====
// Testbench for the PDP-8 accumulator unit
// Drives the AXI4-Lite window from a vector file, waits for busy to fall
// and checks AC, MQ, link and bus responses, with random bready and
// rready stalls from an LFSR.
`timescale 1ns/1ps

module tb_acc_unit;

    localparam int MAX_WAIT  = 50;  // cycles per handshake
    localparam int MAX_POLLS = 40;  // status reads per instruction

    logic                                 clk;
    logic                                 reset;
    logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] awaddr;
    logic                                 awvalid;
    logic                                 awready;
    logic [31:0]                          wdata;
    logic [3:0]                           wstrb;
    logic                                 wvalid;
    logic                                 wready;
    logic [1:0]                           bresp;
    logic                                 bvalid;
    logic                                 bready;
    logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] araddr;
    logic                                 arvalid;
    logic                                 arready;
    logic [31:0]                          rdata;
    logic [1:0]                           rresp;
    logic                                 rvalid;
    logic                                 rready;
    logic [31:0]                          lfsr;

    acc_unit u_acc_unit (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);  // one step per bit
        end
    endtask

    task automatic check_word(input string what, input logic [pdp8_acc_pkg::WORD_W-1:0] got,
                              input logic [pdp8_acc_pkg::WORD_W-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("Error at time %0t: %s expected %03h, got %03h",
                               $time, what, exp, got));
    endtask

    task automatic check_link(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Error at time %0t: %s link expected %b, got %b",
                               $time, what, exp, got));
    endtask

    task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("Error at time %0t: %s response expected %0d, got %0d",
                               $time, what, exp, got));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Error at time %0t: %s expected %b, got %b",
                               $time, what, exp, got));
    endtask

    task automatic check_upper(input string what, input logic [31:0] got);
        if (got[31:pdp8_acc_pkg::WORD_W] !== '0)
            fail_run($sformatf("Error at time %0t: %s upper bits expected 0, got %05h",
                               $time, what, got[31:pdp8_acc_pkg::WORD_W]));
    endtask

    // called and returns on a falling edge
    task automatic axil_write(input logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] addr,
                              input logic [31:0] data, output logic [1:0] resp);
        int waited;
        int stall;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!awready)
        begin
            if (waited == MAX_WAIT)
                fail_run("Timeout: the write address and data were never accepted");
            waited++;
            @(posedge clk);
        end
        check_flag("wready with awready", wready, 1'b1);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_flag("bvalid after write handshake", bvalid, 1'b1);
        draw_bits(2, stall);
        repeat (stall) @(negedge clk);
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] addr,
                             output logic [31:0] data, output logic [1:0] resp);
        int waited;
        int stall;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!arready)
        begin
            if (waited == MAX_WAIT)
                fail_run("Timeout: the read address was never accepted");
            waited++;
            @(posedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        check_flag("rvalid after read handshake", rvalid, 1'b1);
        draw_bits(2, stall);
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        check_upper($sformatf("read of %02h", addr), data);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        axil_read(pdp8_acc_pkg::ADDR_STATUS, status, resp);
        while (status[pdp8_acc_pkg::STATUS_BUSY])
        begin
            if (polls == MAX_POLLS)
                fail_run("Timeout: busy never fell after an instruction");
            polls++;
            axil_read(pdp8_acc_pkg::ADDR_STATUS, status, resp);
        end
        check_resp("status poll", resp, pdp8_acc_pkg::RESP_OKAY);
    endtask

    task automatic check_state(input logic [pdp8_acc_pkg::WORD_W-1:0] exp_ac,
                               input logic [pdp8_acc_pkg::WORD_W-1:0] exp_mq,
                               input logic exp_link, input string tag);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(pdp8_acc_pkg::ADDR_AC, data, resp);
        check_resp({tag, " AC read"}, resp, pdp8_acc_pkg::RESP_OKAY);
        check_word({tag, " AC"}, data[11:0], exp_ac);
        axil_read(pdp8_acc_pkg::ADDR_MQ, data, resp);
        check_resp({tag, " MQ read"}, resp, pdp8_acc_pkg::RESP_OKAY);
        check_word({tag, " MQ"}, data[11:0], exp_mq);
        axil_read(pdp8_acc_pkg::ADDR_STATUS, data, resp);
        check_resp({tag, " status read"}, resp, pdp8_acc_pkg::RESP_OKAY);
        check_link(tag, data[pdp8_acc_pkg::STATUS_LINK], exp_link);
    endtask

    initial
    begin
        int                              fd;
        int                              fields;
        int                              line_no;
        int                              applied;
        string                           line;
        string                           tag;
        logic [31:0]                     data;
        logic [1:0]                      resp;
        logic [4:0]                      v_addr;
        logic [11:0]                     v_raw;
        logic [1:0]                      v_resp;
        logic [11:0]                     v_ac;
        logic [11:0]                     v_mq;
        logic                            v_link;
        pdp8_acc_pkg::instr_t            v_instr;

        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        lfsr    = 32'h4001_ad7b;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_state('0, '0, 1'b0, "after reset");
        axil_read(pdp8_acc_pkg::ADDR_STATUS, data, resp);
        check_word("status after reset", data[11:0], '0);   // busy low too
        axil_read(5'h14, data, resp);
        check_resp("unmapped read", resp, pdp8_acc_pkg::RESP_SLVERR);
        check_word("unmapped read", data[11:0], '0);

        fd = $fopen("sim/acc_vectors.txt", "r");
        if (fd == 0)
            fail_run("Could not open the vector file sim/acc_vectors.txt");
        line_no = 0;
        applied = 0;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() > 1 && line[0] != "#")
            begin
                fields = $sscanf(line, "%h %h %h %h %h %h",
                                 v_addr, v_raw, v_resp, v_ac, v_mq, v_link);
                if (fields != 6)
                    fail_run($sformatf("Vector line %0d could not be parsed", line_no));
                tag     = $sformatf("vector line %0d", line_no);
                v_instr = v_raw;
                axil_write(v_addr, {20'b0, v_raw}, resp);
                check_resp({tag, " write"}, resp, v_resp);
                // long EAE runs leave room for a rejected second instruction
                if (v_addr == pdp8_acc_pkg::ADDR_INSTR && !v_link &&
                    (v_instr == pdp8_acc_pkg::INSTR_MUL || v_instr == pdp8_acc_pkg::INSTR_DIV))
                begin
                    axil_write(pdp8_acc_pkg::ADDR_INSTR, {20'b0, pdp8_acc_pkg::INSTR_CAM}, resp);
                    check_resp({tag, " write while busy"}, resp, pdp8_acc_pkg::RESP_SLVERR);
                end
                wait_idle();
                check_state(v_ac, v_mq, v_link, tag);
                applied++;
            end
        end
        $fclose(fd);
        if (applied == 0)
            fail_run("The vector file held no vectors");

        if (u_acc_unit.u_props.fail_count != 0)
            fail_run("Concurrent assertions on the bus or busy flag failed");
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== sim/acc_unit_properties.sv ====
// Bus handshake and busy flag properties for the accumulator unit
// Bound into acc_unit and sampled on every rising clock edge.
`timescale 1ns/1ps

module acc_unit_properties (
    input logic clk,
    input logic reset,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic start,
    input logic busy
);

    int unsigned fail_count = 0;

    bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
    else
    begin
        fail_count++;
        $error("bvalid fell before bready");
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
    else
    begin
        fail_count++;
        $error("rvalid fell before rready");
    end

    busy_needs_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start))
    else
    begin
        fail_count++;
        $error("busy rose without a start pulse");
    end

    no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy)
    else
    begin
        fail_count++;
        $error("start pulsed while busy");
    end

endmodule

bind acc_unit acc_unit_properties u_props (
    .clk    (clk),
    .reset  (reset),
    .bvalid (bvalid),
    .bready (bready),
    .rvalid (rvalid),
    .rready (rready),
    .start  (u_cmd_if.start),
    .busy   (u_cmd_if.busy)
);

// ==== hdl/acc_unit.sv ====
// PDP-8 accumulator unit with mode A EAE
// Top level: AXI4-Lite register block, accumulator datapath and the
// multiply/divide unit, joined by the command and EAE interfaces.
`timescale 1ns/1ps

module acc_unit (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [31:0]                          wdata,
    input  logic [3:0]                           wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [31:0]                          rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready
);

    acc_cmd_if u_cmd_if ();
    eae_if     u_eae_if ();

    acc_axil_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (u_cmd_if)
    );

    acc_datapath u_datapath (
        .clk   (clk),
        .reset (reset),
        .cmd   (u_cmd_if),
        .eae   (u_eae_if)
    );

    eae_muldiv u_eae (
        .clk   (clk),
        .reset (reset),
        .eae   (u_eae_if)
    );

endmodule

// ==== hdl/eae_muldiv.sv ====
// EAE mode A multiply and divide
// Iterates over the 24-bit AC:MQ pair, one bit per step. MUL is shift
// and add, DIV is restoring; a divide with AC at or above the divisor
// sets link and ends after a single step.
`timescale 1ns/1ps

module eae_muldiv (
    input  logic clk,
    input  logic reset,
    eae_if.eae   eae
);

    logic [pdp8_acc_pkg::WORD_W-1:0] ac_r;
    logic [pdp8_acc_pkg::WORD_W-1:0] mq_r;
    logic [pdp8_acc_pkg::WORD_W-1:0] opnd;
    logic                            link_r;
    logic                            dvd;
    logic                            ovf;
    logic                            running;
    logic                            done_r;
    logic [3:0]                      step;
    logic [12:0]                     mul_sum;
    logic [12:0]                     trial;

    assign ovf     = eae.divide && (eae.ac_in >= eae.operand);
    assign mul_sum = {1'b0, ac_r} + {1'b0, opnd};
    assign trial   = {ac_r, mq_r[11]} - {1'b0, opnd};   // bit 12 set on borrow

    assign eae.done     = done_r;
    assign eae.ac_out   = ac_r;
    assign eae.mq_out   = mq_r;
    assign eae.link_out = link_r;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running <= 1'b0;
            done_r  <= 1'b0;
            step    <= 4'd0;
        end
        else
        begin
            done_r <= 1'b0;
            if (eae.go)
            begin
                running <= 1'b1;
                step    <= ovf ? 4'd1 : 4'(pdp8_acc_pkg::EAE_STEPS);
            end
            else if (running)
            begin
                step <= step - 4'd1;
                if (step == 4'd1)
                begin
                    running <= 1'b0;
                    done_r  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (eae.go)
        begin
            ac_r   <= eae.ac_in;
            mq_r   <= eae.mq_in;
            opnd   <= eae.operand;
            dvd    <= eae.divide;
            link_r <= ovf;          // MUL always clears link
        end
        else if (running)
        begin
            if (!dvd)
            begin
                if (mq_r[0])
                    {ac_r, mq_r} <= {mul_sum, mq_r[11:1]};
                else
                    {ac_r, mq_r} <= {1'b0, ac_r, mq_r[11:1]};
            end
            else if (link_r)
                mq_r <= {mq_r[10:0], 1'b1};     // overflow, AC kept
            else if (!trial[12])
            begin
                ac_r <= trial[11:0];
                mq_r <= {mq_r[10:0], 1'b1};
            end
            else
            begin
                ac_r <= {ac_r[10:0], mq_r[11]};   // failed trial, keep shifted value
                mq_r <= {mq_r[10:0], 1'b0};
            end
        end
    end

endmodule

// ==== hdl/acc_datapath.sv ====
// PDP-8 accumulator datapath
// Owns AC, MQ and link. Group 1 operate runs in three phases (clear and
// complement, increment, rotate); AND, TAD and the MQ transfers take one
// cycle; MUL and DIV are handed to the EAE and finish on its done pulse.
`timescale 1ns/1ps

module acc_datapath (
    input  logic        clk,
    input  logic        reset,
    acc_cmd_if.datapath cmd,
    eae_if.master       eae
);

    pdp8_acc_pkg::instr_t            ir;
    logic [pdp8_acc_pkg::WORD_W-1:0] opnd;
    logic [pdp8_acc_pkg::WORD_W-1:0] ac;
    logic [pdp8_acc_pkg::WORD_W-1:0] mq;
    logic                            link;
    logic                            busy;
    logic [1:0]                      phase;
    logic                            ir_eae;
    logic                            ir_grp1;

    assign ir_eae  = (ir == pdp8_acc_pkg::INSTR_MUL) || (ir == pdp8_acc_pkg::INSTR_DIV);
    assign ir_grp1 = (ir.opr.opcode == pdp8_acc_pkg::OPC_OPR) && !ir.opr.group;

    // EAE request leaves with the start pulse so it sees the current AC and MQ
    assign eae.go      = cmd.start && ((cmd.instr == pdp8_acc_pkg::INSTR_MUL) ||
                                       (cmd.instr == pdp8_acc_pkg::INSTR_DIV));
    assign eae.divide  = (cmd.instr == pdp8_acc_pkg::INSTR_DIV);
    assign eae.ac_in   = ac;
    assign eae.mq_in   = mq;
    assign eae.operand = cmd.operand;

    assign cmd.busy = busy;
    assign cmd.ac   = ac;
    assign cmd.mq   = mq;
    assign cmd.link = link;

    always_ff @(posedge clk)
    begin
        if (cmd.start)
        begin
            ir   <= cmd.instr;
            opnd <= cmd.operand;    // host may rewrite the operand while busy
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            phase <= 2'd0;
            ac    <= '0;
            mq    <= '0;
            link  <= 1'b0;
        end
        else if (cmd.start)
        begin
            busy  <= 1'b1;
            phase <= 2'd0;
        end
        else if (busy)
        begin
            if (ir_eae)
            begin
                if (eae.done)
                begin
                    ac   <= eae.ac_out;
                    mq   <= eae.mq_out;
                    link <= eae.link_out;
                    busy <= 1'b0;
                end
            end
            else if (ir_grp1)
            begin
                phase <= phase + 2'd1;
                case (phase)
                    2'd0:   // phase A, clear before complement
                    begin
                        ac   <= (ir.opr.micro.cla ? '0 : ac) ^ {12{ir.opr.micro.cma}};
                        link <= (ir.opr.micro.cll ? 1'b0 : link) ^ ir.opr.micro.cml;
                    end
                    2'd1:   // phase B
                    begin
                        if (ir.opr.micro.iac)
                            {link, ac} <= {link, ac} + 13'd1;   // carry flips link
                    end
                    default:    // phase C
                    begin
                        case ({ir.opr.micro.rar, ir.opr.micro.ral, ir.opr.micro.twice})
                            3'b010:  {link, ac} <= {ac, link};                  // RAL
                            3'b011:  {link, ac} <= {ac[10:0], link, ac[11]};    // RTL
                            3'b100:  {link, ac} <= {ac[0], link, ac[11:1]};     // RAR
                            3'b101:  {link, ac} <= {ac[1:0], link, ac[11:2]};   // RTR
                            3'b001:  ac <= {ac[5:0], ac[11:6]};                 // BSW
                            default: ;
                        endcase
                        busy  <= 1'b0;
                        phase <= 2'd0;
                    end
                endcase
            end
            else
            begin
                busy <= 1'b0;
                case (ir.mem.opcode)
                    pdp8_acc_pkg::OPC_AND: ac <= ac & opnd;
                    pdp8_acc_pkg::OPC_TAD: {link, ac} <= {link, ac} + {1'b0, opnd};
                    pdp8_acc_pkg::OPC_OPR:
                    case (ir)
                        pdp8_acc_pkg::INSTR_MQL:
                        begin
                            mq <= ac;
                            ac <= '0;
                        end
                        pdp8_acc_pkg::INSTR_MQA: ac <= ac | mq;
                        pdp8_acc_pkg::INSTR_SWP:
                        begin
                            mq <= ac;
                            ac <= mq;
                        end
                        pdp8_acc_pkg::INSTR_CAM:
                        begin
                            mq <= '0;
                            ac <= '0;
                        end
                        default: ;  // unsupported group 2/3 codes act as NOP
                    endcase
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/acc_axil_regs.sv ====
// AXI4-Lite register block of the accumulator unit
// Holds the operand and instruction registers, pulses start for an
// accepted instruction write and returns AC, MQ and status on reads.
`timescale 1ns/1ps

module acc_axil_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [31:0]                          wdata,
    input  logic [3:0]                           wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [pdp8_acc_pkg::AXIL_ADDR_W-1:0] araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [31:0]                          rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    acc_cmd_if.regs                              cmd
);

    logic                            wr_hs;
    logic                            rd_hs;
    logic                            busy_any;
    logic                            start_q;
    logic                            instr_ok;
    logic [pdp8_acc_pkg::WORD_W-1:0] operand_q;
    pdp8_acc_pkg::instr_t            instr_q;
    logic [pdp8_acc_pkg::WORD_W-1:0] rd_word;
    logic                            rd_ok;

    assign wr_hs    = awvalid & wvalid & ~bvalid;   // address and data taken together
    assign awready  = wr_hs;
    assign wready   = wr_hs;
    assign rd_hs    = arvalid & ~rvalid;
    assign arready  = rd_hs;
    assign busy_any = cmd.busy | start_q;           // covers the cycle before busy rises
    assign instr_ok = (awaddr == pdp8_acc_pkg::ADDR_INSTR) && !busy_any;

    assign cmd.start   = start_q;
    assign cmd.instr   = instr_q;
    assign cmd.operand = operand_q;

    always_comb
    begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (araddr)
            pdp8_acc_pkg::ADDR_OPERAND: rd_word = operand_q;
            pdp8_acc_pkg::ADDR_INSTR:   rd_word = instr_q;
            pdp8_acc_pkg::ADDR_AC:      rd_word = cmd.ac;
            pdp8_acc_pkg::ADDR_MQ:      rd_word = cmd.mq;
            pdp8_acc_pkg::ADDR_STATUS:
            begin
                rd_word[pdp8_acc_pkg::STATUS_LINK] = cmd.link;
                rd_word[pdp8_acc_pkg::STATUS_BUSY] = busy_any;
            end
            default: rd_ok = 1'b0;                  // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start_q <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            start_q <= wr_hs && instr_ok;
            if (wr_hs)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_hs)
        begin
            bresp <= pdp8_acc_pkg::RESP_SLVERR;
            if (awaddr == pdp8_acc_pkg::ADDR_OPERAND)
            begin
                if (wstrb[0])
                    operand_q[7:0] <= wdata[7:0];
                if (wstrb[1])
                    operand_q[11:8] <= wdata[11:8];
                bresp <= pdp8_acc_pkg::RESP_OKAY;
            end
            else if (instr_ok)
            begin
                instr_q <= wdata[11:0];
                bresp   <= pdp8_acc_pkg::RESP_OKAY;
            end
        end
        if (rd_hs)
        begin
            rdata <= {20'b0, rd_word};
            rresp <= rd_ok ? pdp8_acc_pkg::RESP_OKAY : pdp8_acc_pkg::RESP_SLVERR;
        end
    end

endmodule

// ==== hdl/eae_if.sv ====
// Request and result path between the datapath and the EAE
// go carries a multiply or divide request with AC, MQ and the operand;
// done returns the new AC, MQ and link for one cycle.
`timescale 1ns/1ps

interface eae_if;

    logic                             go;
    logic                             divide;   // 0 for MUL
    logic [pdp8_acc_pkg::WORD_W-1:0]  ac_in;
    logic [pdp8_acc_pkg::WORD_W-1:0]  mq_in;
    logic [pdp8_acc_pkg::WORD_W-1:0]  operand;
    logic                             done;
    logic [pdp8_acc_pkg::WORD_W-1:0]  ac_out;
    logic [pdp8_acc_pkg::WORD_W-1:0]  mq_out;
    logic                             link_out;

    modport master (output go, divide, ac_in, mq_in, operand, input done, ac_out, mq_out, link_out);
    modport eae    (input go, divide, ac_in, mq_in, operand, output done, ac_out, mq_out, link_out);

endinterface

// ==== hdl/acc_cmd_if.sv ====
// Command and result path between the register block and the datapath
// The register side issues a start pulse with instruction and operand;
// the datapath returns busy and the AC, MQ and link state.
`timescale 1ns/1ps

interface acc_cmd_if;

    logic                             start;    // one cycle per accepted instruction
    pdp8_acc_pkg::instr_t             instr;
    logic [pdp8_acc_pkg::WORD_W-1:0]  operand;
    logic                             busy;
    logic [pdp8_acc_pkg::WORD_W-1:0]  ac;
    logic [pdp8_acc_pkg::WORD_W-1:0]  mq;
    logic                             link;

    modport regs     (output start, instr, operand, input busy, ac, mq, link);
    modport datapath (input start, instr, operand, output busy, ac, mq, link);

endinterface

// ==== hdl/pdp8_acc_pkg.sv ====
// PDP-8 accumulator unit shared definitions
// Word width, instruction codes, AXI4-Lite register map, response codes
// and the instruction word union decoded by the datapath.
package pdp8_acc_pkg;

    localparam int WORD_W      = 12;
    localparam int AXIL_ADDR_W = 5;
    localparam int EAE_STEPS   = 12;    // one iteration per bit

    // full instruction words, octal as in the handbook
    localparam logic [WORD_W-1:0] INSTR_MUL = 12'o7405;
    localparam logic [WORD_W-1:0] INSTR_DIV = 12'o7407;
    localparam logic [WORD_W-1:0] INSTR_MQL = 12'o7421;
    localparam logic [WORD_W-1:0] INSTR_MQA = 12'o7501;
    localparam logic [WORD_W-1:0] INSTR_SWP = 12'o7521;
    localparam logic [WORD_W-1:0] INSTR_CAM = 12'o7621;

    localparam logic [2:0] OPC_AND = 3'o0;
    localparam logic [2:0] OPC_TAD = 3'o1;
    localparam logic [2:0] OPC_OPR = 3'o7;

    localparam logic [AXIL_ADDR_W-1:0] ADDR_OPERAND = 5'h00;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_INSTR   = 5'h04;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_AC      = 5'h08;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_MQ      = 5'h0C;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS  = 5'h10;

    localparam int STATUS_LINK = 0;
    localparam int STATUS_BUSY = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // bit 11 here is PDP-8 bit 0
    typedef union packed {
        struct packed {
            logic [2:0] opcode;
            logic       indirect;
            logic       page;       // current page vs page zero
            logic [6:0] offset;
        } mem;
        struct packed {
            logic [2:0] opcode;
            logic       group;      // 0 selects group 1
            struct packed {
                logic cla, cll, cma, cml, rar, ral, twice, iac;
            } micro;
        } opr;
    } instr_t;

endpackage
